// File: datapath_params.svh
`ifndef DATAPATH_PARAMS_SVH
`define DATAPATH_PARAMS_SVH

// sizes shared by the package and the datapath blocks

`define WORD_WIDTH 32 // data word bits

`define REG_COUNT 32 // register addresses incl. zero reg

`define ADDR_WIDTH 5 // bits to address REG_COUNT entries

// this register reads as zero, and any write to it is dropped
`define ZERO_REG 31

`endif

// File: dataPathPkg.sv
`include "datapath_params.svh"

package dataPathPkg;

	typedef logic [`WORD_WIDTH-1:0] wordT; // one data word

	typedef logic [`ADDR_WIDTH-1:0] regAddrT; // register index

	// function unit operation codes
	typedef enum logic [3:0] {
		passA    = 4'd0,  // A
		incA     = 4'd1,  // A + 1
		addAB    = 4'd2,  // A + B
		addAB1   = 4'd3,  // A + B + 1
		addANotB = 4'd4,  // A + ~B
		subAB    = 4'd5,  // A + ~B + 1
		decA     = 4'd6,  // A - 1
		andAB    = 4'd7,  // A & B
		orAB     = 4'd8,  // A | B
		xorAB    = 4'd9,  // A ^ B
		notA     = 4'd10, // ~A
		passB    = 4'd11, // B
		shrB     = 4'd12, // B >> 1, logical
		shlB     = 4'd13  // B << 1
	} funcSelT; // codes 14 and 15 act as passA

	// flags from the function unit
	typedef struct packed {
		logic overflow; // signed overflow, add family only
		logic carry;    // carry out or shifted-out bit
		logic negative; // msb of result
		logic zero;     // result is all zeros
	} statusT;

endpackage

// File: regFileIf.sv
`include "datapath_params.svh"

interface regFileIf;
	import dataPathPkg::*;

	wordT writeData; // value to store
	regAddrT writeAddr; // destination register
	logic writeEn; // store on the rising edge
	regAddrT selA; // read port A select
	regAddrT selB; // read port B select
	wordT busA; // read port A data
	wordT busB; // read port B data

	// register file side
	modport store (
		input writeData, writeAddr, writeEn,
		input selA, selB,
		output busA, busB
	);

	// router side
	modport user (
		output writeData, writeAddr, writeEn,
		output selA, selB,
		input busA, busB
	);

endinterface

// File: registerFile.sv
`include "datapath_params.svh"

module registerFile (
	input logic clock,
	input logic rstN,
	regFileIf.store rf
);
	import dataPathPkg::*;

	localparam regAddrT zeroAddr = regAddrT'(`ZERO_REG);

	wordT store [0:`REG_COUNT-2]; // real storage, no entry for the zero reg
	logic [`ZERO_REG-1:0] loadEn; // decoded and qualified write enables

	// one load-enabled register per address below the zero reg
	for (genvar i = 0; i < `ZERO_REG; i++) begin : genStore
		assign loadEn[i] = rf.writeEn && (rf.writeAddr == regAddrT'(i)); // decode & enable

		always_ff @(posedge clock or negedge rstN) begin
			if (!rstN) begin
				store[i] <= '0; // all registers zero after reset
			end else if (loadEn[i]) begin
				store[i] <= rf.writeData;
			end
		end
	end

	// read mux, zero reg has no storage behind it
	function automatic wordT readPort(input regAddrT sel);
		wordT value;
		if (sel == zeroAddr) begin
			value = '0;
		end else begin
			value = store[sel];
		end
		return value;
	endfunction

	always_comb begin
		rf.busA = readPort(rf.selA); // combinational, no bypass
		rf.busB = readPort(rf.selB);
	end

	// a write to a real register is seen on either port one edge later
	writeReadBack: assert property (
		@(posedge clock) disable iff (!rstN)
		(rf.writeEn && rf.writeAddr != zeroAddr) |=>
			((rf.selA != $past(rf.writeAddr) || rf.busA == $past(rf.writeData)) &&
			 (rf.selB != $past(rf.writeAddr) || rf.busB == $past(rf.writeData)))
	) else $error("register %0d did not read back its written value", $past(rf.writeAddr));

	// zero reg holds zero even after writes to it
	zeroRegReadsZero: assert property (
		@(posedge clock) disable iff (!rstN)
		(rf.selA == zeroAddr) |-> (rf.busA == '0)
	) else $error("busA nonzero while zero register selected");

endmodule

// File: functionUnit.sv
`include "datapath_params.svh"

module functionUnit (
	input dataPathPkg::funcSelT funcSel,
	input dataPathPkg::wordT operandA,
	input dataPathPkg::wordT operandB,
	output dataPathPkg::wordT result,
	output dataPathPkg::statusT status
);
	import dataPathPkg::*;

	localparam int msb = `WORD_WIDTH - 1;

	logic addFamily; // code uses the adder
	wordT addend; // second adder input
	logic carryIn;
	logic [`WORD_WIDTH:0] sum; // carry out in the top bit

	wordT logicResult; // logic ops, passB, passA
	logic isShift;
	wordT shiftResult;
	logic shiftOut; // bit that falls off the end

	// pick the adder's B side and carry in
	always_comb begin
		addFamily = 1'b1;
		addend = '0;
		carryIn = 1'b0;
		case (funcSel)
			incA: carryIn = 1'b1;
			addAB: addend = operandB;
			addAB1: begin
				addend = operandB;
				carryIn = 1'b1;
			end
			addANotB: addend = ~operandB;
			subAB: begin
				addend = ~operandB; // two's complement subtract
				carryIn = 1'b1;
			end
			decA: addend = '1; // A + all ones = A - 1
			default: addFamily = 1'b0;
		endcase
	end

	assign sum = {1'b0, operandA} + {1'b0, addend} + {{`WORD_WIDTH{1'b0}}, carryIn};

	// logic path
	always_comb begin
		case (funcSel)
			andAB: logicResult = operandA & operandB;
			orAB: logicResult = operandA | operandB;
			xorAB: logicResult = operandA ^ operandB;
			notA: logicResult = ~operandA;
			passB: logicResult = operandB;
			default: logicResult = operandA; // passA and spare codes
		endcase
	end

	// shift path, one bit either way on B
	always_comb begin
		isShift = 1'b1;
		case (funcSel)
			shrB: begin
				shiftResult = {1'b0, operandB[msb:1]};
				shiftOut = operandB[0];
			end
			shlB: begin
				shiftResult = {operandB[msb-1:0], 1'b0};
				shiftOut = operandB[msb];
			end
			default: begin
				isShift = 1'b0;
				shiftResult = '0;
				shiftOut = 1'b0;
			end
		endcase
	end

	assign result = addFamily ? sum[msb:0] : (isShift ? shiftResult : logicResult);

	always_comb begin
		// overflow when both adder inputs share a sign the sum does not
		status.overflow = addFamily && (operandA[msb] == addend[msb]) &&
			(sum[msb] != operandA[msb]);
		status.carry = addFamily ? sum[`WORD_WIDTH] : shiftOut; // shiftOut is 0 otherwise
		status.negative = result[msb];
		status.zero = addFamily ? (sum[msb:0] == '0) :
			(isShift ? (shiftResult == '0) : (logicResult == '0)); // from the chosen path
	end

	always_comb begin
		zeroFlagMatches: assert final (status.zero == (result == '0))
			else $error("zero flag disagrees with result %h", result);
	end

endmodule

// File: operandRouter.sv
`include "datapath_params.svh"

module operandRouter (
	input dataPathPkg::regAddrT destAddr,
	input dataPathPkg::regAddrT srcAddrA,
	input dataPathPkg::regAddrT srcAddrB,
	input logic writeEn,
	input logic useConstant,
	input logic loadExternal,
	input dataPathPkg::wordT constantIn,
	input dataPathPkg::wordT dataIn,
	input dataPathPkg::wordT funcResult,
	output dataPathPkg::wordT operandB,
	regFileIf.user rf
);
	import dataPathPkg::*;

	wordT writeValue; // chosen write-back source

	// register addressing straight from the control word
	assign rf.selA = srcAddrA;
	assign rf.selB = srcAddrB;
	assign rf.writeAddr = destAddr;
	assign rf.writeEn = writeEn;

	// B side, register or immediate
	always_comb begin
		if (useConstant) begin
			operandB = constantIn;
		end else begin
			operandB = rf.busB;
		end
	end

	// write-back, external load or function unit
	always_comb begin
		if (loadExternal) begin
			writeValue = dataIn;
		end else begin
			writeValue = funcResult;
		end
	end

	assign rf.writeData = writeValue;

endmodule

// File: dataPath.sv
`include "datapath_params.svh"

module dataPath (
	input logic clock,
	input logic rstN,
	input dataPathPkg::regAddrT destAddr,
	input dataPathPkg::regAddrT srcAddrA,
	input dataPathPkg::regAddrT srcAddrB,
	input logic writeEn,
	input logic useConstant,
	input dataPathPkg::wordT constantIn,
	input dataPathPkg::funcSelT funcSel,
	input logic loadExternal,
	input dataPathPkg::wordT dataIn,
	output dataPathPkg::wordT addressOut,
	output dataPathPkg::wordT dataOut,
	output dataPathPkg::wordT result,
	output dataPathPkg::statusT status
);
	import dataPathPkg::*;

	wordT operandB; // B after constant select
	wordT funcResult;

	regFileIf rfBus ();

	operandRouter router0 (
		.destAddr(destAddr),
		.srcAddrA(srcAddrA),
		.srcAddrB(srcAddrB),
		.writeEn(writeEn),
		.useConstant(useConstant),
		.loadExternal(loadExternal),
		.constantIn(constantIn),
		.dataIn(dataIn),
		.funcResult(funcResult),
		.operandB(operandB),
		.rf(rfBus.user)
	);

	registerFile regs0 (
		.clock(clock),
		.rstN(rstN),
		.rf(rfBus.store)
	);

	functionUnit fu0 (
		.funcSel(funcSel),
		.operandA(rfBus.busA),
		.operandB(operandB),
		.result(funcResult),
		.status(status)
	);

	assign addressOut = rfBus.busA; // A bus doubles as address
	assign dataOut = operandB;
	assign result = funcResult;

endmodule

// File: tbClock.sv
module tbClock (
	input logic resetReq, // extra reset pulse from the test sequence
	output logic clock,
	output logic rstN
);
	logic powerOnN;

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock; // period 20
	end

	initial begin
		powerOnN = 1'b0;
		repeat (16) @(posedge clock);
		#2 powerOnN = 1'b1; // released on the drive point
	end

	assign rstN = powerOnN && !resetReq;

endmodule

// File: dataPathTb.sv
`include "datapath_params.svh"

module dataPathTb;
	import dataPathPkg::*;

	localparam int resetCycles = 16;
	localparam int writeTrials = 40;
	localparam int opTrials = 12; // per function code
	localparam int wbTrials = 40;
	localparam int rawTrials = 20;
	localparam int plannedCycles = resetCycles + `REG_COUNT + (2 * writeTrials + 2) + 4 +
		16 * opTrials + 2 * wbTrials + 2 * rawTrials + (2 + `REG_COUNT);
	localparam int timeLimit = (plannedCycles + 100) * 20; // 100 cycles of margin

	logic clock;
	logic rstN;
	logic resetReq;

	regAddrT destAddr;
	regAddrT srcAddrA;
	regAddrT srcAddrB;
	logic writeEn;
	logic useConstant;
	wordT constantIn;
	funcSelT funcSel;
	logic loadExternal;
	wordT dataIn;
	wordT addressOut;
	wordT dataOut;
	wordT result;
	statusT status;

	wordT model [0:`REG_COUNT-1]; // mirror of the register file
	logic [31:0] lcgState;
	int passCount;
	int failCount;

	tbClock clockGen (
		.resetReq(resetReq),
		.clock(clock),
		.rstN(rstN)
	);

	dataPath dut0 (
		.clock(clock),
		.rstN(rstN),
		.destAddr(destAddr),
		.srcAddrA(srcAddrA),
		.srcAddrB(srcAddrB),
		.writeEn(writeEn),
		.useConstant(useConstant),
		.constantIn(constantIn),
		.funcSel(funcSel),
		.loadExternal(loadExternal),
		.dataIn(dataIn),
		.addressOut(addressOut),
		.dataOut(dataOut),
		.result(result),
		.status(status)
	);

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return {lcgState[15:0], lcgState[31:16]}; // high state bits are the better ones
	endfunction

	function automatic regAddrT randAddr();
		logic [31:0] r;
		r = nextRand();
		return r[4:0];
	endfunction

	// any register with storage behind it
	function automatic regAddrT randStoredReg();
		return regAddrT'(nextRand() % 31);
	endfunction

	// corner values now and then
	function automatic wordT pickOperand();
		logic [31:0] r;
		r = nextRand();
		case (r[2:0])
			3'd0: return 32'h0000_0000;
			3'd1: return 32'hffff_ffff;
			3'd2: return 32'h8000_0000;
			3'd3: return 32'h7fff_ffff;
			default: return nextRand();
		endcase
	endfunction

	function automatic wordT readModel(input regAddrT addr);
		return (addr == regAddrT'(`ZERO_REG)) ? wordT'(0) : model[addr];
	endfunction

	// expected result and flags straight from the operation rules
	function automatic void modelCompute(input funcSelT op, input wordT a, input wordT b,
			output wordT r, output statusT s);
		logic [63:0] wide;
		s = '0;
		case (op)
			incA: begin
				r = a + 32'd1;
				s.carry = (a == 32'hffff_ffff);
				s.overflow = (a == 32'h7fff_ffff);
			end
			addAB, addAB1: begin
				wide = {32'd0, a} + {32'd0, b} + ((op == addAB1) ? 64'd1 : 64'd0);
				r = wide[31:0];
				s.carry = wide[32];
				s.overflow = (a[31] == b[31]) && (r[31] != a[31]);
			end
			addANotB: begin
				r = a - b - 32'd1; // A + ~B is A - B - 1
				s.carry = (a > b);
				s.overflow = (a[31] != b[31]) && (r[31] != a[31]);
			end
			subAB: begin
				r = a - b;
				s.carry = (a >= b); // no borrow
				s.overflow = (a[31] != b[31]) && (r[31] != a[31]);
			end
			decA: begin
				r = a - 32'd1;
				s.carry = (a != 32'd0);
				s.overflow = (a == 32'h8000_0000);
			end
			andAB: r = a & b;
			orAB: r = a | b;
			xorAB: r = a ^ b;
			notA: r = ~a;
			passB: r = b;
			shrB: begin
				r = b >> 1;
				s.carry = b[0];
			end
			shlB: begin
				r = b << 1;
				s.carry = b[31];
			end
			default: r = a; // passA and the two spare codes
		endcase
		s.negative = r[31];
		s.zero = (r == 32'd0);
	endfunction

	task automatic checkWord(input string field, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) begin
			passCount++;
		end else begin
			failCount++;
			$display("ERROR %0t: %s expected %h, got %h", $time, field, expected, actual);
		end
	endtask

	task automatic checkBit(input string field, input logic expected, input logic actual);
		assert (actual === expected) begin
			passCount++;
		end else begin
			failCount++;
			$display("ERROR %0t: %s flag expected %b, got %b", $time, field, expected, actual);
		end
	endtask

	task automatic driveIdle();
		destAddr = '0;
		srcAddrA = '0;
		srcAddrB = '0;
		writeEn = 1'b0;
		useConstant = 1'b0;
		constantIn = '0;
		funcSel = passA;
		loadExternal = 1'b0;
		dataIn = '0;
	endtask

	// entered 2 units after an edge, leaves 2 units after the next one
	task automatic runCycle();
		wordT expA;
		wordT expB;
		wordT expResult;
		statusT expStatus;
		wordT writeValue;
		#16; // just before the edge
		expA = readModel(srcAddrA);
		expB = useConstant ? constantIn : readModel(srcAddrB);
		modelCompute(funcSel, expA, expB, expResult, expStatus);
		checkWord("addressOut", expA, addressOut);
		checkWord("dataOut", expB, dataOut);
		checkWord("result", expResult, result);
		checkBit("overflow", expStatus.overflow, status.overflow);
		checkBit("carry", expStatus.carry, status.carry);
		checkBit("negative", expStatus.negative, status.negative);
		checkBit("zero", expStatus.zero, status.zero);
		writeValue = loadExternal ? dataIn : expResult;
		@(posedge clock);
		if (writeEn && destAddr != regAddrT'(`ZERO_REG)) begin
			model[destAddr] = writeValue;
		end
		#2;
	endtask

	task automatic readAll();
		for (int i = 0; i < `REG_COUNT; i++) begin
			driveIdle();
			srcAddrA = regAddrT'(i);
			srcAddrB = regAddrT'(`REG_COUNT - 1 - i); // other port walks backwards
			runCycle();
		end
	endtask

	task automatic reportTest(input int num, input string name, input int failsBefore);
		$display("test %0d %s finished, %0d failed checks", num, name, failCount - failsBefore);
	endtask

	initial begin
		int startFails;
		regAddrT r;
		logic [31:0] pick;
		lcgState = 32'hf84c;
		passCount = 0;
		failCount = 0;
		resetReq = 1'b0;
		driveIdle();
		foreach (model[i]) begin
			model[i] = '0;
		end
		wait (rstN === 1'b1);

		startFails = failCount;
		readAll();
		reportTest(1, "reset clears registers", startFails);

		startFails = failCount;
		for (int n = 0; n < writeTrials; n++) begin
			r = randStoredReg();
			driveIdle();
			destAddr = r;
			writeEn = 1'b1;
			loadExternal = 1'b1;
			dataIn = nextRand();
			srcAddrA = randAddr();
			srcAddrB = randAddr();
			runCycle();
			driveIdle();
			srcAddrA = r;
			srcAddrB = r;
			runCycle();
		end
		driveIdle();
		destAddr = regAddrT'(`ZERO_REG);
		writeEn = 1'b1;
		loadExternal = 1'b1;
		dataIn = nextRand() | 32'd1; // never zero
		runCycle();
		driveIdle();
		srcAddrA = regAddrT'(`ZERO_REG);
		srcAddrB = regAddrT'(`ZERO_REG);
		runCycle();
		reportTest(2, "external writes", startFails);

		startFails = failCount;
		// corner values into regs 0..3 for the A side
		for (int i = 0; i < 4; i++) begin
			driveIdle();
			destAddr = regAddrT'(i);
			writeEn = 1'b1;
			loadExternal = 1'b1;
			case (i)
				0: dataIn = 32'h7fff_ffff;
				1: dataIn = 32'h8000_0000;
				2: dataIn = 32'hffff_ffff;
				default: dataIn = 32'h0000_0001;
			endcase
			runCycle();
		end
		for (int op = 0; op < 16; op++) begin
			for (int t = 0; t < opTrials; t++) begin
				driveIdle();
				pick = nextRand();
				funcSel = funcSelT'(op[3:0]);
				srcAddrA = pick[0] ? regAddrT'(pick[2:1]) : randAddr();
				srcAddrB = randAddr();
				useConstant = pick[5];
				constantIn = pickOperand();
				runCycle();
			end
		end
		reportTest(3, "function codes", startFails);

		startFails = failCount;
		for (int n = 0; n < wbTrials; n++) begin
			r = randStoredReg();
			driveIdle();
			pick = nextRand();
			funcSel = funcSelT'(pick[3:0]);
			srcAddrA = n[0] ? r : randAddr(); // every other trial dest equals a source
			srcAddrB = randAddr();
			useConstant = pick[4];
			constantIn = pickOperand();
			destAddr = r;
			writeEn = 1'b1;
			runCycle();
			driveIdle();
			srcAddrA = r;
			srcAddrB = r;
			runCycle();
		end
		reportTest(4, "result write-back", startFails);

		startFails = failCount;
		for (int n = 0; n < rawTrials; n++) begin
			r = randStoredReg();
			driveIdle();
			destAddr = r;
			srcAddrA = r;
			srcAddrB = r;
			writeEn = 1'b1;
			loadExternal = 1'b1;
			dataIn = nextRand();
			runCycle(); // old value expected here
			writeEn = 1'b0;
			runCycle();
		end
		reportTest(5, "read during write", startFails);

		startFails = failCount;
		driveIdle();
		resetReq = 1'b1; // registers clear right away
		foreach (model[i]) begin
			model[i] = '0;
		end
		repeat (2) @(posedge clock);
		#2 resetReq = 1'b0;
		readAll();
		reportTest(6, "reset mid-run", startFails);

		$display("checks passed: %0d, checks failed: %0d", passCount, failCount);
		if (failCount == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

	initial begin
		#(timeLimit);
		$display("simulation hung, watchdog expired at %0t", $time);
		$display("Done: errors found");
		$finish;
	end

endmodule

// File: all.f
+incdir+.
dataPathPkg.sv
regFileIf.sv
registerFile.sv
functionUnit.sv
operandRouter.sv
dataPath.sv
tbClock.sv
dataPathTb.sv

// File: Makefile
SOURCES := $(shell grep -v '^+' all.f)

.PHONY: all run clean

all: run

obj_dir/simDataPath: $(SOURCES) datapath_params.svh all.f
	verilator --binary --timing --assert -Wno-fatal -f all.f \
		--top-module dataPathTb -o simDataPath

run: obj_dir/simDataPath
	./obj_dir/simDataPath | tee sim.log
	grep -q "^Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log
